// File: Bender.yml
package:
  name: fp_module

export_include_dirs:
  - include

sources:
  - hdl/fp_format_pkg.sv
  - hdl/fp_op_pkg.sv
  - hdl/fp_norm_if.sv
  - hdl/fp_round.sv
  - hdl/fp_sub.sv
  - hdl/fp_mul.sv
  - hdl/fp_class.sv
  - hdl/fp_module.sv
  - target: test
    files:
      - sim/tb_fp_module.sv

// File: hdl/fp_class.sv
`include "fp_config.svh"

module fp_class (
    input  logic                     i_sign,
    input  fp_format_pkg::fp_exp_t   i_exp,
    input  fp_format_pkg::fp_frac_t  i_frac,
    output fp_op_pkg::fp_class_t     o_class
);

    logic exp_max;
    logic exp_zero;
    logic frac_zero;

    assign exp_max   = (i_exp == `FP_EXP_MAX);
    assign exp_zero  = (i_exp == '0);
    assign frac_zero = (i_frac == '0);

    always_comb begin
        o_class = '0;
        if (exp_max && !frac_zero) begin
            // Fraction MSB tells quiet from signaling
            o_class[9] = i_frac[`FP_MAN_W-1];
            o_class[8] = ~i_frac[`FP_MAN_W-1];
        end else if (exp_max) begin
            o_class[7] = ~i_sign;
            o_class[0] = i_sign;
        end else if (exp_zero && frac_zero) begin
            o_class[4] = ~i_sign;
            o_class[3] = i_sign;
        end else if (exp_zero) begin
            o_class[5] = ~i_sign;
            o_class[2] = i_sign;
        end else begin
            o_class[6] = ~i_sign;
            o_class[1] = i_sign;
        end
    end

endmodule

// File: hdl/fp_format_pkg.sv
`include "fp_config.svh"

package fp_format_pkg;

    // Raw operand or result word
    typedef logic [`FP_WIDTH-1:0] fp_word_t;

    // Biased exponent field
    typedef logic [`FP_EXP_W-1:0] fp_exp_t;

    // Stored fraction without the hidden bit
    typedef logic [`FP_MAN_W-1:0] fp_frac_t;

    // Significand with the hidden bit on top
    typedef logic [`FP_MAN_W:0] fp_sig_t;

    // Significand followed by guard, round and sticky
    typedef logic [`FP_MAN_W+`FP_GRS_W:0] fp_sig_grs_t;

    // Working exponent, two extra bits so it can leave the 1..254 range
    typedef logic signed [`FP_EXP_W+1:0] fp_exp_wide_t;

endpackage

// File: hdl/fp_module.sv
`include "fp_config.svh"

module fp_module (
    input  logic                     i_clk,
    input  logic                     i_rst,
    input  fp_format_pkg::fp_word_t  i_data_r1,
    input  fp_format_pkg::fp_word_t  i_data_r2,
    input  logic [`FP_OP_W-1:0]      i_alu_ctrl,
    output fp_format_pkg::fp_word_t  o_data,
    output logic                     o_invalid
);

    logic                     sign_a;
    logic                     sign_b;
    fp_format_pkg::fp_exp_t   exp_a;
    fp_format_pkg::fp_exp_t   exp_b;
    fp_format_pkg::fp_frac_t  frac_a;
    fp_format_pkg::fp_frac_t  frac_b;
    fp_format_pkg::fp_sig_t   sig_a;
    fp_format_pkg::fp_sig_t   sig_b;
    fp_format_pkg::fp_word_t  sub_result;
    fp_format_pkg::fp_word_t  mul_result;
    logic                     sub_range_inv;
    logic                     mul_range_inv;
    fp_op_pkg::fp_class_t     class_code;
    logic                     nan_inf;
    fp_op_pkg::fp_op_e        op;
    fp_format_pkg::fp_word_t  data_next;
    logic                     invalid_next;

    // Operand fields, hidden bit set for any nonzero exponent
    assign sign_a = i_data_r1[`FP_WIDTH-1];
    assign sign_b = i_data_r2[`FP_WIDTH-1];
    assign exp_a  = i_data_r1[`FP_WIDTH-2 -: `FP_EXP_W];
    assign exp_b  = i_data_r2[`FP_WIDTH-2 -: `FP_EXP_W];
    assign frac_a = i_data_r1[`FP_MAN_W-1:0];
    assign frac_b = i_data_r2[`FP_MAN_W-1:0];
    assign sig_a  = {(exp_a != '0), frac_a};
    assign sig_b  = {(exp_b != '0), frac_b};

    fp_norm_if sub_norm ();
    fp_norm_if mul_norm ();

    fp_sub fp_sub_inst (
        .i_sign_a (sign_a),
        .i_sign_b (sign_b),
        .i_exp_a  (exp_a),
        .i_exp_b  (exp_b),
        .i_sig_a  (sig_a),
        .i_sig_b  (sig_b),
        .o_norm   (sub_norm)
    );

    fp_mul fp_mul_inst (
        .i_sign_a (sign_a),
        .i_sign_b (sign_b),
        .i_exp_a  (exp_a),
        .i_exp_b  (exp_b),
        .i_sig_a  (sig_a),
        .i_sig_b  (sig_b),
        .o_norm   (mul_norm)
    );

    fp_round fp_round_sub_inst (
        .i_norm          (sub_norm),
        .o_result        (sub_result),
        .o_range_invalid (sub_range_inv)
    );

    fp_round fp_round_mul_inst (
        .i_norm          (mul_norm),
        .o_result        (mul_result),
        .o_range_invalid (mul_range_inv)
    );

    fp_class fp_class_inst (
        .i_sign  (sign_a),
        .i_exp   (exp_a),
        .i_frac  (frac_a),
        .o_class (class_code)
    );

    // Inf or NaN on either operand
    assign nan_inf = (exp_a == `FP_EXP_MAX) || (exp_b == `FP_EXP_MAX);

    assign op = fp_op_pkg::fp_op_e'(i_alu_ctrl);

    always_comb begin
        case (op)
            fp_op_pkg::FP_FSUB: begin
                data_next    = sub_result;
                invalid_next = sub_range_inv | nan_inf;
            end
            fp_op_pkg::FP_FMUL: begin
                data_next    = mul_result;
                invalid_next = mul_range_inv | nan_inf;
            end
            fp_op_pkg::FP_FCLASS: begin
                data_next    = class_code;
                invalid_next = 1'b0;
            end
            default: begin
                data_next    = '0;
                invalid_next = 1'b0;
            end
        endcase
    end

    // One cycle of latency, a new operation every cycle
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            o_data    <= '0;
            o_invalid <= 1'b0;
        end else begin
            o_data    <= data_next;
            o_invalid <= invalid_next;
        end
    end

    a_fclass_valid: assert property (
        @(posedge i_clk) disable iff (i_rst)
        (i_alu_ctrl == fp_op_pkg::FP_FCLASS) |=> !o_invalid
    );

    a_unknown_zero: assert property (
        @(posedge i_clk) disable iff (i_rst)
        !(i_alu_ctrl inside {fp_op_pkg::FP_FSUB, fp_op_pkg::FP_FMUL, fp_op_pkg::FP_FCLASS})
        |=> (o_data == '0) && !o_invalid
    );

    // A range flag from the rounder only ever leaves infinity or zero
    a_range_flag_special: assert property (
        @(posedge i_clk) disable iff (i_rst)
        ((i_alu_ctrl inside {fp_op_pkg::FP_FSUB, fp_op_pkg::FP_FMUL}) && !nan_inf)
        |=> (!o_invalid
             || (((o_data[`FP_WIDTH-2 -: `FP_EXP_W] == `FP_EXP_MAX)
                  || (o_data[`FP_WIDTH-2 -: `FP_EXP_W] == '0))
                 && (o_data[`FP_MAN_W-1:0] == '0)))
    );

endmodule

// File: hdl/fp_mul.sv
`include "fp_config.svh"

module fp_mul (
    input  logic                    i_sign_a,
    input  logic                    i_sign_b,
    input  fp_format_pkg::fp_exp_t  i_exp_a,
    input  fp_format_pkg::fp_exp_t  i_exp_b,
    input  fp_format_pkg::fp_sig_t  i_sig_a,
    input  fp_format_pkg::fp_sig_t  i_sig_b,
    fp_norm_if.producer             o_norm
);

    localparam int SIG_W  = `FP_MAN_W + `FP_GRS_W + 1;
    localparam int PROD_W = 2 * (`FP_MAN_W + 1);

    logic                        zero_op;
    logic [PROD_W-1:0]           product;
    fp_format_pkg::fp_exp_wide_t exp_sum;

    // Hidden bit is zero only for a zero exponent, so a zero significand means a zero operand
    assign zero_op = (i_sig_a == '0) || (i_sig_b == '0);

    assign product = i_sig_a * i_sig_b;

    assign exp_sum = fp_format_pkg::fp_exp_wide_t'({2'b00, i_exp_a})
                   + fp_format_pkg::fp_exp_wide_t'({2'b00, i_exp_b})
                   - fp_format_pkg::fp_exp_wide_t'(`FP_BIAS);

    always_comb begin
        o_norm.sign = i_sign_a ^ i_sign_b;
        o_norm.exp  = exp_sum;
        o_norm.zero = 1'b0;
        if (zero_op) begin
            o_norm.sign = 1'b0;
            o_norm.exp  = '0;
            o_norm.sig  = '0;
            o_norm.zero = 1'b1;
        end else if (product[PROD_W-1]) begin
            // Product in [2,4), top bit is the new hidden bit
            o_norm.sig = {product[PROD_W-1 -: SIG_W-1], |product[PROD_W-SIG_W:0]};
            o_norm.exp = exp_sum + 1;
        end else begin
            o_norm.sig = {product[PROD_W-2 -: SIG_W-1], |product[PROD_W-SIG_W-1:0]};
        end
    end

endmodule

// File: hdl/fp_norm_if.sv
interface fp_norm_if;

    // Normalized, still unrounded result
    logic                        sign;
    fp_format_pkg::fp_exp_wide_t exp;
    fp_format_pkg::fp_sig_grs_t  sig;
    // Exact zero, packed as +0 by the rounder
    logic                        zero;

    modport producer (
        output sign, exp, sig, zero
    );

    modport consumer (
        input sign, exp, sig, zero
    );

endinterface

// File: hdl/fp_op_pkg.sv
`include "fp_config.svh"

package fp_op_pkg;

    // Operation codes handled by the unit
    typedef enum logic [`FP_OP_W-1:0] {
        FP_FSUB   = `FP_OP_FSUB,
        FP_FMUL   = `FP_OP_FMUL,
        FP_FCLASS = `FP_OP_FCLASS
    } fp_op_e;

    // One-hot class code, only bits 0 to 9 are ever set
    //   0 -inf, 1 -normal, 2 -subnormal, 3 -zero
    //   4 +zero, 5 +subnormal, 6 +normal, 7 +inf
    //   8 signaling NaN, 9 quiet NaN
    typedef logic [`FP_WIDTH-1:0] fp_class_t;

endpackage

// File: hdl/fp_round.sv
`include "fp_config.svh"

module fp_round (
    fp_norm_if.consumer              i_norm,
    output fp_format_pkg::fp_word_t  o_result,
    output logic                     o_range_invalid
);

    localparam int SIG_W = `FP_MAN_W + `FP_GRS_W + 1;

    fp_format_pkg::fp_frac_t     frac_trunc;
    logic                        guard_bit;
    logic                        round_bit;
    logic                        sticky_bit;
    logic                        round_up;
    logic [`FP_MAN_W:0]          frac_inc;
    fp_format_pkg::fp_exp_wide_t exp_rnd;
    fp_format_pkg::fp_exp_t      exp_out;
    fp_format_pkg::fp_frac_t     frac_out;

    // Bit 26 is the hidden bit, 25..3 the fraction, 2..0 GRS
    assign frac_trunc = i_norm.sig[SIG_W-2 -: `FP_MAN_W];
    assign guard_bit  = i_norm.sig[2];
    assign round_bit  = i_norm.sig[1];
    assign sticky_bit = i_norm.sig[0];

    // Nearest-even: above half rounds up, exact half goes to the even fraction
    assign round_up = guard_bit & (round_bit | sticky_bit | frac_trunc[0]);
    assign frac_inc = {1'b0, frac_trunc} + round_up;

    // Fraction carry-out bumps the exponent, the fraction is already zero then
    assign exp_rnd = i_norm.exp + fp_format_pkg::fp_exp_wide_t'(frac_inc[`FP_MAN_W]);

    always_comb begin
        exp_out         = '0;
        frac_out        = '0;
        o_range_invalid = 1'b0;
        if (i_norm.zero) begin
            // Exact zero, nothing to flag
            exp_out = '0;
        end else if (i_norm.exp >= `FP_EXP_MAX) begin
            // Overflow to infinity
            exp_out         = '1;
            o_range_invalid = 1'b1;
        end else if (i_norm.exp <= 0) begin
            // No subnormal results, flush to zero
            o_range_invalid = (i_norm.sig != '0);
        end else if (exp_rnd >= `FP_EXP_MAX) begin
            // Rounding carried past the largest exponent
            exp_out         = '1;
            o_range_invalid = 1'b1;
        end else begin
            exp_out  = exp_rnd[`FP_EXP_W-1:0];
            frac_out = frac_inc[`FP_MAN_W-1:0];
        end
    end

    // A zero exponent with zero fraction always leaves as +0
    assign o_result = (exp_out == '0 && frac_out == '0) ? '0 :
                      {i_norm.sign, exp_out, frac_out};

endmodule

// File: hdl/fp_sub.sv
`include "fp_config.svh"

module fp_sub (
    input  logic                    i_sign_a,
    input  logic                    i_sign_b,
    input  fp_format_pkg::fp_exp_t  i_exp_a,
    input  fp_format_pkg::fp_exp_t  i_exp_b,
    input  fp_format_pkg::fp_sig_t  i_sig_a,
    input  fp_format_pkg::fp_sig_t  i_sig_b,
    fp_norm_if.producer             o_norm
);

    localparam int SIG_W = `FP_MAN_W + `FP_GRS_W + 1;

    logic                        sign_b_eff;
    logic                        a_ge_b;
    fp_format_pkg::fp_exp_t      exp_diff;
    fp_format_pkg::fp_exp_wide_t exp_large;
    fp_format_pkg::fp_sig_grs_t  pad_a;
    fp_format_pkg::fp_sig_grs_t  pad_b;
    fp_format_pkg::fp_sig_grs_t  sig_big;
    fp_format_pkg::fp_sig_grs_t  sig_small;
    fp_format_pkg::fp_sig_grs_t  shift_mask;
    fp_format_pkg::fp_sig_grs_t  sig_small_al;
    fp_format_pkg::fp_sig_grs_t  al_a;
    fp_format_pkg::fp_sig_grs_t  al_b;
    logic                        sticky;
    logic [SIG_W:0]              mag_sum;
    logic                        sum_sign;
    logic [4:0]                  lead_pos;
    logic [4:0]                  left_shift;

    // a - b is a + (-b)
    assign sign_b_eff = ~i_sign_b;

    assign a_ge_b    = (i_exp_a >= i_exp_b);
    assign exp_diff  = a_ge_b ? (i_exp_a - i_exp_b) : (i_exp_b - i_exp_a);
    assign exp_large = fp_format_pkg::fp_exp_wide_t'({2'b00, (a_ge_b ? i_exp_a : i_exp_b)});

    assign pad_a = {i_sig_a, {`FP_GRS_W{1'b0}}};
    assign pad_b = {i_sig_b, {`FP_GRS_W{1'b0}}};

    // Smaller operand slides right, lost bits collapse into sticky
    assign sig_big      = a_ge_b ? pad_a : pad_b;
    assign sig_small    = a_ge_b ? pad_b : pad_a;
    assign shift_mask   = ~({SIG_W{1'b1}} << exp_diff);
    assign sticky       = |(sig_small & shift_mask);
    assign sig_small_al = (sig_small >> exp_diff) | {{(SIG_W-1){1'b0}}, sticky};

    assign al_a = a_ge_b ? sig_big : sig_small_al;
    assign al_b = a_ge_b ? sig_small_al : sig_big;

    // Magnitude add or subtract, sign follows the larger magnitude
    always_comb begin
        if (i_sign_a == sign_b_eff) begin
            mag_sum  = al_a + al_b;
            sum_sign = i_sign_a;
        end else if (al_a >= al_b) begin
            mag_sum  = al_a - al_b;
            sum_sign = i_sign_a;
        end else begin
            mag_sum  = al_b - al_a;
            sum_sign = sign_b_eff;
        end
    end

    // Highest set bit below the carry position
    always_comb begin
        lead_pos = '0;
        for (int i = 0; i < SIG_W; i++) begin
            if (mag_sum[i]) begin
                lead_pos = 5'(i);
            end
        end
    end

    assign left_shift = 5'(SIG_W - 1) - lead_pos;

    always_comb begin
        o_norm.sign = sum_sign;
        o_norm.zero = 1'b0;
        if (mag_sum == '0) begin
            o_norm.exp  = '0;
            o_norm.sig  = '0;
            o_norm.zero = 1'b1;
        end else if (mag_sum[SIG_W]) begin
            // Carry out, one step right and keep the dropped bit as sticky
            o_norm.sig = {mag_sum[SIG_W:2], mag_sum[1] | mag_sum[0]};
            o_norm.exp = exp_large + 1;
        end else begin
            o_norm.sig = mag_sum[SIG_W-1:0] << left_shift;
            o_norm.exp = exp_large - fp_format_pkg::fp_exp_wide_t'({5'b00000, left_shift});
        end
    end

endmodule

// File: include/fp_config.svh
`ifndef FP_CONFIG_SVH
`define FP_CONFIG_SVH

// IEEE 754 single precision layout
`define FP_WIDTH     32
`define FP_EXP_W     8
`define FP_MAN_W     23
`define FP_BIAS      127
`define FP_EXP_MAX   255

// Guard, round and sticky bits below the significand
`define FP_GRS_W     3

// Operation codes on i_alu_ctrl
`define FP_OP_W      5
`define FP_OP_FSUB   5'b01010
`define FP_OP_FMUL   5'b01011
`define FP_OP_FCLASS 5'b01111

`endif

// File: sim/tb_fp_module.sv
`include "fp_config.svh"

module tb_fp_module;

    localparam int N_RAND      = 20;
    // Idle, directed classes, directed sub, rounding, exceptions, unknown codes, three random runs
    localparam int TOTAL_OPS   = 1 + 10 + 3 + 3 + 6 + 29 + 3 * N_RAND;
    localparam int CYCLE_LIMIT = 2 * TOTAL_OPS + 20;

    typedef struct packed {
        logic [31:0] data;
        logic        inv;
        logic        data_en;
    } expect_t;

    logic                    i_clk;
    logic                    i_rst;
    fp_format_pkg::fp_word_t i_data_r1;
    fp_format_pkg::fp_word_t i_data_r2;
    logic [`FP_OP_W-1:0]     i_alu_ctrl;
    fp_format_pkg::fp_word_t o_data;
    logic                    o_invalid;

    expect_t     exp_q[$];
    expect_t     head;
    logic        chk_valid   = 1'b0;
    logic [31:0] chk_data    = '0;
    logic        chk_inv     = 1'b0;
    logic        chk_data_en = 1'b0;
    logic        failed      = 1'b0;
    int          cycle_count = 0;

    // Entry i targets class bit i
    fp_format_pkg::fp_word_t class_words [10] = '{
        32'hFF800000, 32'hBF800000, 32'h80000001, 32'h80000000, 32'h00000000,
        32'h00400000, 32'h3F800000, 32'h7F800000, 32'h7F800001, 32'h7FC00000
    };

    fp_module fp_module_inst (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_data_r1  (i_data_r1),
        .i_data_r2  (i_data_r2),
        .i_alu_ctrl (i_alu_ctrl),
        .o_data     (o_data),
        .o_invalid  (o_invalid)
    );

    initial begin
        i_clk = 1'b0;
        forever #10 i_clk = ~i_clk;
    end

    task automatic end_with_failure();
        failed = 1'b1;
        $display("TEST RESULT: FAIL");
        $fatal(1, "run stopped on the first error");
    endtask

    task automatic report_mismatch(string name, logic [31:0] expv, logic [31:0] gotv);
        $display("mismatch at time %0t: %s expected %h got %h", $time, name, expv, gotv);
        end_with_failure();
    endtask

    // Class index from sign, exponent and fraction
    function automatic int class_index(fp_format_pkg::fp_word_t w);
        if (w[30:23] == 8'hff && w[22:0] != '0)
            return w[22] ? 9 : 8;
        if (w[30:23] == 8'hff)
            return w[31] ? 0 : 7;
        if (w[30:23] == 8'h00 && w[22:0] == '0)
            return w[31] ? 3 : 4;
        if (w[30:23] == 8'h00)
            return w[31] ? 2 : 5;
        return w[31] ? 1 : 6;
    endfunction

    function automatic real to_real(fp_format_pkg::fp_word_t w);
        real v;
        if (w[30:23] == 8'h00) begin
            v = real'(w[22:0]) * (2.0 ** (-149));
            return w[31] ? -v : v;
        end
        return $bitstoreal({w[31], 11'(int'(w[30:23]) + 896), w[22:0], 29'b0});
    endfunction

    // Single result from an exact real value, flag in bit 32
    function automatic logic [32:0] round_to_single(real r);
        logic [63:0] bits;
        logic        sign;
        int          e;
        logic [23:0] frac;
        logic        g;
        logic        rest;
        bits = $realtobits(r);
        sign = bits[63];
        e    = int'(bits[62:52]) - 1023 + 127;
        frac = {1'b0, bits[51:29]};
        g    = bits[28];
        rest = |bits[27:0];
        if (r == 0.0)
            return 33'h0;
        if (e <= 0)
            return {1'b1, 32'h0};
        if (e >= 255)
            return {1'b1, sign, 8'hff, 23'h0};
        frac = frac + 24'(g & (rest | frac[0]));
        if (frac[23])
            e = e + 1;
        if (e >= 255)
            return {1'b1, sign, 8'hff, 23'h0};
        return {1'b0, sign, 8'(e), frac[22:0]};
    endfunction

    // Twelve significant bits, so sums and products stay exact
    function automatic fp_format_pkg::fp_word_t short_operand(logic [7:0] e);
        return {1'($urandom), e, 11'($urandom), 12'b0};
    endfunction

    task automatic issue_op(logic [4:0] op, fp_format_pkg::fp_word_t a,
                            fp_format_pkg::fp_word_t b, logic [31:0] exp_data,
                            logic exp_inv, logic data_en);
        @(posedge i_clk);
        #2;
        i_data_r1  = a;
        i_data_r2  = b;
        i_alu_ctrl = op;
        exp_q.push_back('{data: exp_data, inv: exp_inv, data_en: data_en});
    endtask

    task automatic sub_case(fp_format_pkg::fp_word_t a, fp_format_pkg::fp_word_t b);
        logic [32:0] ref_val;
        ref_val = round_to_single(to_real(a) - to_real(b));
        issue_op(`FP_OP_FSUB, a, b, ref_val[31:0], ref_val[32], 1'b1);
    endtask

    task automatic mul_case(fp_format_pkg::fp_word_t a, fp_format_pkg::fp_word_t b);
        logic [32:0] ref_val;
        ref_val = round_to_single(to_real(a) * to_real(b));
        issue_op(`FP_OP_FMUL, a, b, ref_val[31:0], ref_val[32], 1'b1);
    endtask

    // One-deep expected queue, lined up with the register stage
    always @(posedge i_clk) begin
        if (exp_q.size() > 0) begin
            head = exp_q.pop_front();
            chk_valid   <= 1'b1;
            chk_data    <= head.data;
            chk_inv     <= head.inv;
            chk_data_en <= head.data_en;
        end else begin
            chk_valid <= 1'b0;
        end
    end

    always @(posedge i_clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= CYCLE_LIMIT) begin
            $display("timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            end_with_failure();
        end
    end

    a_reset_state: assert property (
        @(posedge i_clk) $fell(i_rst) |-> (o_data == '0) && !o_invalid
    ) else begin
        $display("reset state wrong: outputs are not zero when reset is released");
        end_with_failure();
    end

    a_data_match: assert property (
        @(posedge i_clk) disable iff (i_rst)
        (chk_valid && chk_data_en) |-> (o_data == chk_data)
    ) else report_mismatch("o_data", $sampled(chk_data), $sampled(o_data));

    a_invalid_match: assert property (
        @(posedge i_clk) disable iff (i_rst)
        chk_valid |-> (o_invalid == chk_inv)
    ) else report_mismatch("o_invalid", 32'($sampled(chk_inv)), 32'($sampled(o_invalid)));

    initial begin
        logic [7:0]              ea;
        logic [7:0]              eb;
        fp_format_pkg::fp_word_t rand_word;
        i_rst      = 1'b1;
        i_data_r1  = '0;
        i_data_r2  = '0;
        i_alu_ctrl = '0;
        void'($urandom(32'hc198));
        repeat (4) @(posedge i_clk);
        #2;
        i_rst = 1'b0;

        issue_op(5'b00000, '0, '0, '0, 1'b0, 1'b1);

        for (int i = 0; i < 10; i++)
            issue_op(`FP_OP_FCLASS, class_words[i], '0, 32'h1 << i, 1'b0, 1'b1);
        for (int i = 0; i < N_RAND; i++) begin
            ea = 8'($urandom);
            rand_word = {1'($urandom), ea, 23'($urandom)};
            issue_op(`FP_OP_FCLASS, rand_word, 32'($urandom),
                     32'h1 << class_index(rand_word), 1'b0, 1'b1);
        end

        sub_case(32'h3FC00000, 32'h3E800000);
        sub_case(32'h40400000, 32'h40400000);
        sub_case(32'hC0000000, 32'h40400000);
        for (int i = 0; i < N_RAND; i++) begin
            ea = 8'(110 + int'($urandom % 31));
            eb = 8'(int'(ea) - 11 + int'($urandom % 23));
            sub_case(short_operand(ea), short_operand(eb));
        end
        for (int i = 0; i < N_RAND; i++) begin
            ea = 8'(100 + int'($urandom % 55));
            eb = 8'(100 + int'($urandom % 55));
            mul_case(short_operand(ea), short_operand(eb));
        end

        // Below half, tie to even down, tie to even up
        mul_case(32'h3F800001, 32'h3F800001);
        mul_case(32'h3F800800, 32'h3F800800);
        mul_case(32'h3FC00000, 32'h3F800001);

        // Inf or NaN operands only have a defined flag
        issue_op(`FP_OP_FSUB, 32'h7F800000, 32'h3F800000, '0, 1'b1, 1'b0);
        issue_op(`FP_OP_FSUB, 32'h3F800000, 32'h7FC00000, '0, 1'b1, 1'b0);
        issue_op(`FP_OP_FMUL, 32'h7F800000, 32'h40000000, '0, 1'b1, 1'b0);
        issue_op(`FP_OP_FMUL, 32'h7FC00001, 32'h3F800000, '0, 1'b1, 1'b0);
        mul_case(32'h7F000000, 32'h40000000);
        mul_case(32'h00800000, 32'h3F000000);

        for (int c = 0; c < 32; c++) begin
            if (c != `FP_OP_FSUB && c != `FP_OP_FMUL && c != `FP_OP_FCLASS)
                issue_op(5'(c), 32'($urandom), 32'($urandom), '0, 1'b0, 1'b1);
        end

        // Last result is checked one edge after it is registered
        repeat (2) @(posedge i_clk);
        #1;
        if (failed == 1'b0) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            end_with_failure();
        end
    end

endmodule

// File: vlog.f
+incdir+include
hdl/fp_format_pkg.sv
hdl/fp_op_pkg.sv
hdl/fp_norm_if.sv
hdl/fp_round.sv
hdl/fp_sub.sv
hdl/fp_mul.sv
hdl/fp_class.sv
hdl/fp_module.sv
sim/tb_fp_module.sv
